// File: build.f
source/game2048Pkg.sv
source/lineShifter.sv
source/boardMover.sv
source/gameControl.sv
source/tileRenderer.sv
source/game2048.sv
verification/game2048_assertions.sv
verification/game2048Tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= game2048Tb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= *** PASSED ***
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/game2048Tb.sv
module game2048Tb import game2048Pkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int winTarget = 5;
    localparam int tableLength = 14;
    localparam int randomMoveLimit = 400;
    localparam int cyclesPerMove = 8;
    localparam int timeoutCycles = 3 * cyclesPerMove * (tableLength + randomMoveLimit);

    logic Clk, Reset, up, down, left, right, bright;
    logic [9:0] hCount, vCount;
    logic ready, won, lost;
    logic [colourBits-1:0] rgb;

    int model [16];
    int seen [16];
    int valueErrors = 0;
    int otherErrors = 0;
    int cycleCount = 0;

    // direction keys as {up, down, left, right} and the expected tile sums
    logic [3:0] tableKeys [tableLength] = '{4'b0010, 4'b0001, 4'b1000, 4'b0100, 4'b1010,
        4'b0001, 4'b0010, 4'b0100, 4'b0110, 4'b1000, 4'b0011, 4'b0001, 4'b1111, 4'b0100};
    int tableSums [tableLength] = '{4, 6, 8, 10, 12, 14, 16, 18, 20, 22, 24, 26, 28, 30};

    game2048 #(.winExponent(winTarget)) DUT (.*);

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("errors: %0d value, %0d other", valueErrors, otherErrors + 1);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic checkLevel(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, got %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    function automatic dir_t pickDir(input logic [3:0] keys);
        if (keys[3]) return dirUp;
        if (keys[2]) return dirDown;
        if (keys[1]) return dirLeft;
        return dirRight;
    endfunction

    // board index of position p along line k where p = 0 sits at the target edge
    function automatic int lineIndex(input dir_t d, input int k, input int p);
        int row;
        int col;
        case (d)
            dirUp: begin
                row = p;
                col = k;
            end
            dirDown: begin
                row = 3 - p;
                col = k;
            end
            dirLeft: begin
                row = k;
                col = p;
            end
            default: begin
                row = k;
                col = 3 - p;
            end
        endcase
        return row * 4 + col;
    endfunction

    function automatic void moveModel(input dir_t d);
        int tiles [$];
        int merged [$];
        for (int k = 0; k < 4; k++) begin
            tiles.delete();
            merged.delete();
            for (int p = 0; p < 4; p++) begin
                if (model[lineIndex(d, k, p)] != 0) tiles.push_back(model[lineIndex(d, k, p)]);
            end
            while (tiles.size() > 0) begin
                if (tiles.size() > 1 && tiles[0] == tiles[1]) begin
                    merged.push_back(tiles[0] + 1);
                    void'(tiles.pop_front());
                    void'(tiles.pop_front());
                end else begin
                    merged.push_back(tiles.pop_front());
                end
            end
            for (int p = 0; p < 4; p++) begin
                model[lineIndex(d, k, p)] = (p < merged.size()) ? merged[p] : 0;
            end
        end
        // new 2 in the first empty cell
        for (int i = 0; i < 16; i++) begin
            if (model[i] == 0) begin
                model[i] = 1;
                break;
            end
        end
    endfunction

    // 1 for win, 2 for lose, 0 while play goes on
    function automatic int modelOutcome();
        int empty;
        empty = 0;
        foreach (model[i]) begin
            if (model[i] == winTarget) return 1;
            if (model[i] == 0) empty++;
        end
        return (empty == 0) ? 2 : 0;
    endfunction

    task automatic readBoard();
        for (int i = 0; i < 16; i++) begin
            hCount = 10'(int'(gridLeft) + (i % gridSize) * cellPitch + cellPixels / 2);
            vCount = 10'(int'(gridTop) + (i / gridSize) * cellPitch + cellPixels / 2);
            bright = 1'b1;
            #1;
            seen[i] = -1;
            for (int e = 0; e < 12; e++) begin
                if (rgb == tileColours[e]) seen[i] = e;
            end
            if (seen[i] < 0) begin
                $display("cell %0d shows colour %h, which belongs to no tile", i, rgb);
                otherErrors++;
            end
        end
        bright = 1'b0;
    endtask

    task automatic compareBoard();
        for (int i = 0; i < 16; i++) begin
            if (seen[i] != model[i]) begin
                $display("** Error board[%0d]: expected %h, got %h", i, model[i], seen[i]);
                valueErrors++;
            end
        end
    endtask

    task automatic doMove(input logic [3:0] keys);
        @(posedge Clk);
        #1;
        checkLevel("ready", ready, 1'b1);
        {up, down, left, right} = keys;
        @(posedge Clk);
        #1;
        // keys held through the move cycle must be ignored
        checkLevel("ready", ready, 1'b0);
        @(posedge Clk);
        #1;
        {up, down, left, right} = 4'b0000;
        checkLevel("ready", ready, 1'b1);
        moveModel(pickDir(keys));
        readBoard();
        compareBoard();
    endtask

    task automatic checkOutcome();
        int outcome;
        outcome = modelOutcome();
        @(posedge Clk);
        #1;
        checkLevel("won", won, outcome == 1);
        checkLevel("lost", lost, outcome == 2);
        checkLevel("ready", ready, outcome == 0);
    endtask

    task automatic checkPixel(input int h, input int v, input logic b, input logic [11:0] exp);
        @(posedge Clk);
        #1;
        hCount = 10'(h);
        vCount = 10'(v);
        bright = b;
        #1;
        if (rgb !== exp) begin
            $display("** Error rgb at (%0d,%0d): expected %h, got %h", h, v, exp, rgb);
            valueErrors++;
        end
    endtask

    initial begin
        int sum;
        int moves;
        logic endWon;
        logic endLost;
        void'($urandom(13937));
        {Reset, up, down, left, right, bright} = 6'b100000;
        hCount = '0;
        vCount = '0;
        repeat (3) @(posedge Clk);
        #1;
        Reset = 1'b0;
        checkLevel("ready", ready, 1'b0);
        checkLevel("won", won, 1'b0);
        checkLevel("lost", lost, 1'b0);
        @(posedge Clk);
        #1;
        checkLevel("ready", ready, 1'b1);
        foreach (model[i]) model[i] = (i == 0) ? 1 : 0;
        readBoard();
        compareBoard();

        for (int n = 0; n < tableLength; n++) begin
            doMove(tableKeys[n]);
            sum = 0;
            foreach (seen[i]) sum += (seen[i] > 0) ? (1 << seen[i]) : 0;
            if (sum != tableSums[n]) begin
                $display("** Error tile sum: expected %h, got %h", tableSums[n], sum);
                valueErrors++;
            end
            checkOutcome();
        end

        moves = 0;
        while (!won && !lost && moves < randomMoveLimit) begin
            doMove(4'b0001 << ($urandom % 4));
            checkOutcome();
            moves++;
        end
        if (!won && !lost) begin
            $display("game neither won nor lost after %0d random moves", moves);
            otherErrors++;
        end

        // direction pulses after the end must not touch the board
        endWon = won;
        endLost = lost;
        for (int i = 0; i < 4; i++) begin
            @(posedge Clk);
            #1;
            {up, down, left, right} = 4'b1000 >> i;
        end
        @(posedge Clk);
        #1;
        {up, down, left, right} = 4'b0000;
        repeat (2) @(posedge Clk);
        #1;
        readBoard();
        compareBoard();
        checkLevel("won", won, endWon);
        checkLevel("lost", lost, endLost);

        checkPixel(390, 190, 1'b0, blankColour);
        checkPixel(int'(gridLeft) + cellPixels, int'(gridTop) + 2, 1'b1, backgroundColour);
        checkPixel(int'(gridLeft) + 2, int'(gridTop) + cellPixels + 1, 1'b1, backgroundColour);
        checkPixel(10, 10, 1'b1, backgroundColour);
        checkPixel(455, 255, 1'b1, tileColours[model[15]]);
        checkPixel(475, 275, 1'b1, tileColours[model[15]]);
        checkPixel(476, 275, 1'b1, backgroundColour);

        $display("errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verification/game2048_assertions.sv
module game2048Assertions (
    input logic       Clk,
    input logic       Reset,
    input logic [4:0] state,
    input logic       accept,
    input logic       ready,
    input logic       won,
    input logic       lost
);
    timeunit 1ns;
    timeprecision 100ps;

    stateOneHot: assert property (@(posedge Clk) disable iff (Reset) $onehot(state))
        else $error("state register is not one-hot");

    endExclusive: assert property (@(posedge Clk) disable iff (Reset) !(won && lost))
        else $error("won and lost are both high");

    // end states hold until reset
    wonSticky: assert property (@(posedge Clk) disable iff (Reset) won |=> won)
        else $error("won fell without reset");

    lostSticky: assert property (@(posedge Clk) disable iff (Reset) lost |=> lost)
        else $error("lost fell without reset");

    acceptDropsReady: assert property (@(posedge Clk) disable iff (Reset) accept |=> !ready)
        else $error("ready stayed high after an accepted move");

endmodule

bind gameControl game2048Assertions assertions (
    .Clk    (Clk),
    .Reset  (Reset),
    .state  (state),
    .accept (accept),
    .ready  (ready),
    .won    (won),
    .lost   (lost)
);

// File: source/game2048.sv
module game2048 import game2048Pkg::*; #(
    parameter int winExponent = defaultWinExponent
) (
    input  logic                  Clk,
    input  logic                  Reset,
    input  logic                  up,
    input  logic                  down,
    input  logic                  left,
    input  logic                  right,
    input  logic [9:0]            hCount,
    input  logic [9:0]            vCount,
    input  logic                  bright,
    output logic                  ready,
    output logic                  won,
    output logic                  lost,
    output logic [colourBits-1:0] rgb
);

    dir_t dir;
    board_t board;
    board_t movedBoard;

    gameControl #(
        .winExponent (winExponent)
    ) control (
        .Clk        (Clk),
        .Reset      (Reset),
        .up         (up),
        .down       (down),
        .left       (left),
        .right      (right),
        .movedBoard (movedBoard),
        .dir        (dir),
        .board      (board),
        .ready      (ready),
        .won        (won),
        .lost       (lost)
    );

    boardMover mover (
        .board      (board),
        .dir        (dir),
        .movedBoard (movedBoard)
    );

    tileRenderer renderer (
        .board  (board),
        .hCount (hCount),
        .vCount (vCount),
        .bright (bright),
        .rgb    (rgb)
    );

endmodule

// File: source/tileRenderer.sv
module tileRenderer import game2048Pkg::*; (
    input  board_t                board,
    input  logic [9:0]            hCount,
    input  logic [9:0]            vCount,
    input  logic                  bright,
    output logic [colourBits-1:0] rgb
);

    logic colHit;
    logic rowHit;
    logic [1:0] col;
    logic [1:0] row;

    // which cell square, if any, holds the pixel
    always_comb begin
        int colStart;
        int rowStart;

        colHit = 1'b0;
        rowHit = 1'b0;
        col = '0;
        row = '0;
        for (int i = 0; i < gridSize; i++) begin
            colStart = int'(gridLeft) + i * cellPitch;
            rowStart = int'(gridTop) + i * cellPitch;
            // both ends inclusive
            if (int'(hCount) >= colStart && int'(hCount) <= colStart + cellPixels - 1) begin
                colHit = 1'b1;
                col = 2'(i);
            end
            if (int'(vCount) >= rowStart && int'(vCount) <= rowStart + cellPixels - 1) begin
                rowHit = 1'b1;
                row = 2'(i);
            end
        end
    end

    always_comb begin
        if (!bright) begin
            rgb = blankColour;
        end else if (rowHit && colHit) begin
            rgb = tileColours[board[{row, col}]];
        end else begin
            // gaps and everything outside the grid
            rgb = backgroundColour;
        end
    end

endmodule

// File: source/gameControl.sv
module gameControl import game2048Pkg::*; #(
    parameter int winExponent = defaultWinExponent
) (
    input  logic   Clk,
    input  logic   Reset,
    input  logic   up,
    input  logic   down,
    input  logic   left,
    input  logic   right,
    input  board_t movedBoard,
    output dir_t   dir,
    output board_t board,
    output logic   ready,
    output logic   won,
    output logic   lost
);

    typedef enum logic [4:0] {
        stateInit  = 5'b00001,
        stateReady = 5'b00010,
        stateMove  = 5'b00100,
        stateWin   = 5'b01000,
        stateLose  = 5'b10000
    } state_t;

    state_t state;

    logic dirValid;
    logic emptyFound;
    logic [3:0] emptyIndex;
    logic winFound;
    logic accept;

    // up wins over down, down over left, left over right
    always_comb begin
        if (up) begin
            dir = dirUp;
        end else if (down) begin
            dir = dirDown;
        end else if (left) begin
            dir = dirLeft;
        end else begin
            dir = dirRight;
        end
    end

    assign dirValid = up | down | left | right;

    // reverse scan leaves the first empty cell in row-major order
    always_comb begin
        emptyFound = 1'b0;
        emptyIndex = '0;
        winFound = 1'b0;
        for (int i = gridSize * gridSize - 1; i >= 0; i--) begin
            if (board[i] == '0) begin
                emptyFound = 1'b1;
                emptyIndex = i[3:0];
            end
            if (board[i] == cell_t'(winExponent)) begin
                winFound = 1'b1;
            end
        end
    end

    assign accept = ready && !winFound && emptyFound && dirValid;

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            state <= stateInit;
        end else begin
            case (state)
                stateInit: state <= stateReady;
                stateReady: begin
                    if (winFound) begin
                        state <= stateWin;
                    end else if (!emptyFound) begin
                        // full board ends the game, merges or not
                        state <= stateLose;
                    end else if (dirValid) begin
                        state <= stateMove;
                    end
                end
                stateMove: state <= stateReady;
                default: state <= state;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == stateInit) begin
            board <= '0;
            board[0] <= cell_t'(1);
        end else if (accept) begin
            board <= movedBoard;
        end else if (state == stateMove && emptyFound) begin
            // spawn a 2
            board[emptyIndex] <= cell_t'(1);
        end
    end

    assign ready = (state == stateReady);
    assign won = (state == stateWin);
    assign lost = (state == stateLose);

endmodule

// File: source/boardMover.sv
module boardMover import game2048Pkg::*; (
    input  board_t board,
    input  dir_t   dir,
    output board_t movedBoard
);

    line_t linesIn  [gridSize];
    line_t linesOut [gridSize];

    // board cell for position p of line k, p = 0 at the target edge
    function automatic int cellIndex(input dir_t d, input int k, input int p);
        int index;
        case (d)
            dirUp: begin
                index = p * gridSize + k;
            end
            dirDown: begin
                index = (gridSize - 1 - p) * gridSize + k;
            end
            dirLeft: begin
                index = k * gridSize + p;
            end
            default: begin
                index = k * gridSize + (gridSize - 1 - p);
            end
        endcase
        return index;
    endfunction

    always_comb begin
        for (int k = 0; k < gridSize; k++) begin
            for (int p = 0; p < gridSize; p++) begin
                linesIn[k][p] = board[cellIndex(dir, k, p)];
            end
        end
    end

    genvar k;
    generate
        for (k = 0; k < gridSize; k++) begin : gLine
            lineShifter shifter (
                .lineIn  (linesIn[k]),
                .lineOut (linesOut[k])
            );
        end
    endgenerate

    // same mapping back onto the board
    always_comb begin
        movedBoard = '0;
        for (int k = 0; k < gridSize; k++) begin
            for (int p = 0; p < gridSize; p++) begin
                movedBoard[cellIndex(dir, k, p)] = linesOut[k][p];
            end
        end
    end

endmodule

// File: source/lineShifter.sv
module lineShifter import game2048Pkg::*; (
    input  line_t lineIn,
    output line_t lineOut
);

    always_comb begin
        // one spare zero cell above the top so i+1 stays in range
        cell_t [gridSize:0] compact;
        int fill;
        logic skip;

        compact = '0;
        fill = 0;
        for (int i = 0; i < gridSize; i++) begin
            if (lineIn[i] != '0) begin
                compact[fill] = lineIn[i];
                fill = fill + 1;
            end
        end

        // merge pairs starting from the target edge
        lineOut = '0;
        fill = 0;
        skip = 1'b0;
        for (int i = 0; i < gridSize; i++) begin
            if (skip) begin
                skip = 1'b0;
            end else if (compact[i] != '0) begin
                if (compact[i] == compact[i+1]) begin
                    lineOut[fill] = compact[i] + cell_t'(1);
                    skip = 1'b1;
                end else begin
                    lineOut[fill] = compact[i];
                end
                fill = fill + 1;
            end
        end
    end

endmodule

// File: source/game2048Pkg.sv
package game2048Pkg;

    // grid geometry
    localparam int gridSize = 4;
    localparam int cellBits = 4;

    // exponent per cell, 0 is empty
    typedef logic [cellBits-1:0] cell_t;

    // index 0 is the cell at the target edge
    typedef cell_t [gridSize-1:0] line_t;

    // row-major, cell (0,0) at index 0
    typedef cell_t [gridSize*gridSize-1:0] board_t;

    typedef enum logic [1:0] {
        dirUp,
        dirDown,
        dirLeft,
        dirRight
    } dir_t;

    // tile 2048
    localparam int defaultWinExponent = 11;

    localparam int colourBits = 12;

    // pixel placement of the grid
    localparam logic [9:0] gridLeft = 10'd380;
    localparam logic [9:0] gridTop = 10'd180;
    localparam int cellPixels = 21;
    localparam int cellPitch = 25;

    // indexed by exponent, entry 0 is an empty cell
    localparam logic [colourBits-1:0] tileColours [0:11] = '{
        12'h666, 12'hEDC, 12'hC98, 12'hD95,
        12'hF84, 12'hF65, 12'hF33, 12'hEB4,
        12'hFB0, 12'h8B5, 12'h4AD, 12'h15D
    };

    localparam logic [colourBits-1:0] backgroundColour = 12'hFFF;
    localparam logic [colourBits-1:0] blankColour = 12'h000;

endpackage
